// File: files.f
arm_mem_pkg.sv
ldst_decode.sv
ldst_execute.sv
ldst_result.sv
arm_regfile.sv
arm_mem_stage.sv
arm_mem_stage_props.sv
tb_bus_memory.sv
tb_arm_mem_stage.sv

// File: tb_arm_mem_stage.sv
`default_nettype none

module tb_arm_mem_stage;

	timeunit 1ns;
	timeprecision 100ps;

	import arm_mem_pkg::*;

	localparam word_t FILL_KEY = 32'h5a3c96e1;
	localparam int STALL_LIMIT = 40;

	logic     clk = 1'b0;
	logic     rst_n;
	insn_t    insn;
	word_t    pc;
	word_t    op0;
	word_t    op1;
	logic     ex_we;
	reg_idx_t ex_sel;
	word_t    ex_data;
	word_t    bus_addr;
	logic     rd_req;
	logic     wr_req;
	word_t    wr_data;
	logic     rw_wait;
	word_t    rd_data;
	logic     writeback;
	reg_idx_t reg_sel;
	word_t    reg_data;
	word_t    out_pc;
	logic     bubble;
	logic     stall;

	word_t model_regs [16];
	word_t model_mem [64];
	int    errors;
	int    assert_fails;

	arm_mem_stage arm_mem_stage_i (.*);

	tb_bus_memory #(.FILL_KEY(FILL_KEY)) bus_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus_addr (bus_addr),
		.rd_req   (rd_req),
		.wr_req   (wr_req),
		.wr_data  (wr_data),
		.rw_wait  (rw_wait),
		.rd_data  (rd_data)
	);

	always #5 clk = ~clk;

	function automatic word_t rotate_load(input word_t w, input logic [1:0] lane);
		return (w >> (8 * lane)) | (w << (32 - 8 * lane));
	endfunction

	// Holds the instruction until the stage stops stalling.
	task automatic present(input string name, input insn_t word, input word_t a, input word_t b);
		int cycles;
		insn = word;
		op0 = a;
		op1 = b;
		pc = pc + 32'd4;
		cycles = 0;
		@(negedge clk);
		while (stall) begin
			cycles++;
			if (cycles > STALL_LIMIT) begin
				$display("Timeout: stall never fell during test %s.", name);
				errors++;
				break;
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic run_ldst(input string name, input logic load, input logic byte_op,
		input logic pre, input logic up_dir, input logic wb, input reg_idx_t rn,
		input reg_idx_t rd, input word_t offset);
		word_t base;
		word_t eff;
		word_t addr;
		word_t val;
		base = model_regs[rn];
		eff = up_dir ? base + offset : base - offset;
		addr = pre ? eff : base;
		if (load) begin
			val = rotate_load(model_mem[addr[7:2]], addr[1:0]);
			model_regs[rd] = byte_op ? {24'h000000, val[7:0]} : val;
		end else begin
			val = byte_op ? {4{model_regs[rd][7:0]}} : model_regs[rd];
			model_mem[addr[7:2]] = val;
		end
		if (wb)
			model_regs[rn] = eff;
		present(name, {4'he, 3'b010, pre, up_dir, byte_op, wb, load, rn, rd, 12'h000},
			base, offset);
	endtask

	task automatic preload(input reg_idx_t sel, input word_t val);
		ex_we = 1'b1;
		ex_sel = sel;
		ex_data = val;
		model_regs[sel] = val;
		@(posedge clk);
		#1;
		ex_we = 1'b0;
	endtask

	// Waits until the sequencer has written everything back.
	task automatic drain();
		int cycles;
		int quiet;
		cycles = 0;
		quiet = 0;
		while (quiet < 3) begin
			@(negedge clk);
			quiet = (stall || writeback) ? 0 : quiet + 1;
			cycles++;
			if (cycles > STALL_LIMIT) begin
				$display("Timeout: the stage did not go idle after the last test.");
				errors++;
				break;
			end
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		insn = '0;
		pc = '0;
		op0 = '0;
		op1 = '0;
		ex_we = 1'b0;
		ex_sel = '0;
		ex_data = '0;
		errors = 0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		for (int i = 0; i < 64; i++)
			model_mem[i] = word_t'(i * 4) ^ FILL_KEY;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		preload(4'd1, 32'h00000040);
		preload(4'd3, 32'ha1b2c3d4);
		preload(4'd4, 32'h13572468);
		preload(4'd5, 32'h00000080);

		run_ldst("ldr_aligned", 1, 0, 1, 1, 0, 4'd1, 4'd6, 32'd4);
		run_ldst("ldr_unaligned", 1, 0, 1, 1, 0, 4'd1, 4'd7, 32'd5);
		run_ldst("ldrb", 1, 1, 1, 1, 0, 4'd1, 4'd8, 32'd7);
		run_ldst("ldr_pre_wb", 1, 0, 1, 1, 1, 4'd1, 4'd9, 32'd8);
		run_ldst("ldr_post_down_wb", 1, 0, 0, 0, 1, 4'd5, 4'd10, 32'd8);
		run_ldst("str_pre_down", 0, 0, 1, 0, 0, 4'd5, 4'd3, 32'd4);
		run_ldst("strb_post_wb", 0, 1, 0, 1, 1, 4'd1, 4'd3, 32'd12);
		run_ldst("str_pre_wb", 0, 0, 1, 1, 1, 4'd1, 4'd4, 32'h10);
		present("undefined", 32'he7912010, model_regs[1], 32'd0);
		present("alu_add", 32'he0812003, model_regs[1], 32'd3);
		run_ldst("ldr_readback", 1, 0, 1, 0, 0, 4'd5, 4'd11, 32'd4);
		run_ldst("ldrb_down", 1, 1, 1, 0, 0, 4'd1, 4'd12, 32'h1d);
		present("idle", 32'h00000000, 32'd0, 32'd0);
		drain();

		for (int i = 0; i < 16; i++)
			check_word($sformatf("final_reg_r%0d", i), model_regs[i],
				arm_mem_stage_i.regfile_i.regs[i]);
		for (int i = 0; i < 64; i++)
			check_word($sformatf("final_mem_%02h", i * 4), model_mem[i], bus_i.mem[i]);

		assert_fails = arm_mem_stage_i.props_i.fail_count;
		$display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_bus_memory.sv
`default_nettype none

module tb_bus_memory #(
	parameter arm_mem_pkg::word_t FILL_KEY = 32'h5a3c96e1
) (
	input  logic               clk,
	input  logic               rst_n,
	input  arm_mem_pkg::word_t bus_addr,
	input  logic               rd_req,
	input  logic               wr_req,
	input  arm_mem_pkg::word_t wr_data,
	output logic               rw_wait,
	output arm_mem_pkg::word_t rd_data
);

	timeunit 1ns;
	timeprecision 100ps;

	import arm_mem_pkg::*;

	word_t      mem [64];
	logic [1:0] wait_left; // Wait states still owed to the current access.

	assign rw_wait = (rd_req | wr_req) && (wait_left != 2'd0);
	assign rd_data = mem[bus_addr[7:2]];

	// The wait count of the next access is drawn as soon as the last one ends.
	initial begin
		void'($urandom(32'hbded9dd6));
		for (int i = 0; i < 64; i++)
			mem[i] = word_t'(i * 4) ^ FILL_KEY;
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				wait_left <= 2'($urandom_range(2, 0));
			end else if (rd_req | wr_req) begin
				if (wait_left != 2'd0) begin
					wait_left <= wait_left - 2'd1;
				end else begin
					if (wr_req)
						mem[bus_addr[7:2]] <= wr_data;
					wait_left <= 2'($urandom_range(2, 0));
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: arm_mem_stage_props.sv
`default_nettype none

module arm_mem_stage_props (
	input logic                  clk,
	input logic                  rst_n,
	input arm_mem_pkg::insn_t    insn,
	input arm_mem_pkg::word_t    pc,
	input arm_mem_pkg::word_t    op0,
	input arm_mem_pkg::word_t    op1,
	input arm_mem_pkg::word_t    bus_addr,
	input logic                  rd_req,
	input logic                  wr_req,
	input arm_mem_pkg::word_t    wr_data,
	input logic                  rw_wait,
	input arm_mem_pkg::word_t    rd_data,
	input logic                  writeback,
	input arm_mem_pkg::reg_idx_t reg_sel,
	input arm_mem_pkg::word_t    reg_data,
	input arm_mem_pkg::word_t    out_pc,
	input logic                  bubble,
	input logic                  stall
);

	timeunit 1ns;
	timeprecision 100ps;

	import arm_mem_pkg::*;

	int    fail_count = 0;
	logic  single;
	logic  ld_done;
	logic  st_done;
	word_t p_eff;
	word_t p_xfer;
	word_t p_rot;
	word_t exp_load;

	assign single = (insn[27:26] == 2'b01) && !(insn[25] && insn[4]);
	assign p_eff = insn[BIT_UP] ? op0 + op1 : op0 - op1;
	assign p_xfer = insn[BIT_PRE] ? p_eff : op0;
	assign p_rot = (rd_data >> (8 * p_xfer[1:0])) | (rd_data << (32 - 8 * p_xfer[1:0]));
	assign exp_load = insn[BIT_BYTE] ? {24'h000000, p_rot[7:0]} : p_rot;
	assign ld_done = rd_req && !rw_wait;
	assign st_done = wr_req && !rw_wait;

	addr_check: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req || wr_req) |-> bus_addr == {p_xfer[31:2], 2'b00})
	else begin
		fail_count++;
		$error("Bus address does not match the indexed base.");
	end

	no_req_check: assert property (@(posedge clk) disable iff (!rst_n)
		!single |-> !rd_req && !wr_req)
	else begin
		fail_count++;
		$error("Request raised for a non-transfer instruction.");
	end

	wait_check: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req || wr_req) && rw_wait |-> stall ##1 !writeback)
	else begin
		fail_count++;
		$error("Wait state did not freeze the stage.");
	end

	load_check: assert property (@(posedge clk) disable iff (!rst_n)
		ld_done |=> writeback && reg_sel == $past(insn[RD_MSB:RD_LSB])
			&& reg_data == $past(exp_load))
	else begin
		fail_count++;
		$error("Load writeback carries the wrong register or data.");
	end

	load_base_check: assert property (@(posedge clk) disable iff (!rst_n)
		ld_done && insn[BIT_WB] |=> stall && !rd_req && !wr_req ##1 writeback
			&& reg_sel == $past(insn[RN_MSB:RN_LSB], 2) && reg_data == $past(p_eff, 2))
	else begin
		fail_count++;
		$error("Load base writeback sequence is wrong.");
	end

	byte_data_check: assert property (@(posedge clk) disable iff (!rst_n)
		st_done && insn[BIT_BYTE] |-> wr_data == {4{wr_data[7:0]}})
	else begin
		fail_count++;
		$error("Byte store data is not replicated on all lanes.");
	end

	store_wb_check: assert property (@(posedge clk) disable iff (!rst_n)
		st_done && insn[BIT_WB] |=> writeback && reg_sel == $past(insn[RN_MSB:RN_LSB])
			&& reg_data == $past(p_eff))
	else begin
		fail_count++;
		$error("Store base writeback is wrong.");
	end

	store_quiet_check: assert property (@(posedge clk) disable iff (!rst_n)
		st_done && !insn[BIT_WB] |=> !writeback)
	else begin
		fail_count++;
		$error("Store without writeback wrote a register.");
	end

	// The stage passes pc and the wait level one cycle down the pipeline.
	pipe_copy_check: assert property (@(posedge clk) disable iff (!rst_n)
		1'b1 |=> out_pc == $past(pc) && bubble == $past(rw_wait))
	else begin
		fail_count++;
		$error("Pipeline copy of pc or rw_wait is wrong.");
	end

	reset_check: assert property (@(posedge clk) !rst_n |=> !writeback && !bubble)
	else begin
		fail_count++;
		$error("Writeback or bubble high after reset.");
	end

endmodule

bind arm_mem_stage arm_mem_stage_props props_i (.*);

`default_nettype wire

// File: arm_mem_stage.sv
`default_nettype none

module arm_mem_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  arm_mem_pkg::insn_t    insn,
	input  arm_mem_pkg::word_t    pc,
	input  arm_mem_pkg::word_t    op0,
	input  arm_mem_pkg::word_t    op1,
	input  logic                  ex_we,
	input  arm_mem_pkg::reg_idx_t ex_sel,
	input  arm_mem_pkg::word_t    ex_data,
	output arm_mem_pkg::word_t    bus_addr,
	output logic                  rd_req,
	output logic                  wr_req,
	output arm_mem_pkg::word_t    wr_data,
	input  logic                  rw_wait,
	input  arm_mem_pkg::word_t    rd_data,
	output logic                  writeback,
	output arm_mem_pkg::reg_idx_t reg_sel,
	output arm_mem_pkg::word_t    reg_data,
	output arm_mem_pkg::word_t    out_pc,
	output logic                  bubble,
	output logic                  stall
);

	import arm_mem_pkg::*;

	ldst_class_t cls;
	logic        is_load;
	logic        is_byte;
	logic        pre_index;
	logic        up;
	logic        wb_base;
	reg_idx_t    rn;
	reg_idx_t    rd;
	reg_idx_t    st_sel;
	word_t       st_data;
	word_t       eff_addr;
	word_t       xfer_addr;
	logic        done;
	logic        res_busy;

	ldst_decode decode_i (
		.insn      (insn),
		.cls       (cls),
		.is_load   (is_load),
		.is_byte   (is_byte),
		.pre_index (pre_index),
		.up        (up),
		.wb_base   (wb_base),
		.rn        (rn),
		.rd        (rd)
	);

	ldst_execute execute_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cls       (cls),
		.is_load   (is_load),
		.is_byte   (is_byte),
		.pre_index (pre_index),
		.up        (up),
		.op0       (op0),
		.op1       (op1),
		.rd        (rd),
		.st_data   (st_data),
		.rw_wait   (rw_wait),
		.res_busy  (res_busy),
		.bus_addr  (bus_addr),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.wr_data   (wr_data),
		.st_sel    (st_sel),
		.eff_addr  (eff_addr),
		.xfer_addr (xfer_addr),
		.done      (done),
		.stall     (stall)
	);

	ldst_result result_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.done      (done),
		.is_load   (is_load),
		.is_byte   (is_byte),
		.wb_base   (wb_base),
		.rn        (rn),
		.rd        (rd),
		.xfer_addr (xfer_addr),
		.eff_addr  (eff_addr),
		.rd_data   (rd_data),
		.writeback (writeback),
		.reg_sel   (reg_sel),
		.reg_data  (reg_data),
		.res_busy  (res_busy)
	);

	arm_regfile regfile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_we    (ex_we),
		.ex_sel   (ex_sel),
		.ex_data  (ex_data),
		.mem_we   (writeback), // Each pulse from the sequencer is one write.
		.mem_sel  (reg_sel),
		.mem_data (reg_data),
		.rd_sel   (st_sel),
		.rd_data  (st_data)
	);

	always_ff @(posedge clk) begin
		out_pc <= pc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			bubble <= 1'b0;
		else
			bubble <= rw_wait;
	end

endmodule

`default_nettype wire

// File: arm_regfile.sv
`default_nettype none

module arm_regfile (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_we,
	input  arm_mem_pkg::reg_idx_t ex_sel,
	input  arm_mem_pkg::word_t    ex_data,
	input  logic                  mem_we,
	input  arm_mem_pkg::reg_idx_t mem_sel,
	input  arm_mem_pkg::word_t    mem_data,
	input  arm_mem_pkg::reg_idx_t rd_sel,
	output arm_mem_pkg::word_t    rd_data
);

	import arm_mem_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else begin
			if (ex_we)
				regs[ex_sel] <= ex_data;
			if (mem_we)
				regs[mem_sel] <= mem_data; // Later write wins on the same register.
		end
	end

	// No bypass. A read sees the value from the last edge.
	assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

// File: ldst_result.sv
`default_nettype none

module ldst_result (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  done,
	input  logic                  is_load,
	input  logic                  is_byte,
	input  logic                  wb_base,
	input  arm_mem_pkg::reg_idx_t rn,
	input  arm_mem_pkg::reg_idx_t rd,
	input  arm_mem_pkg::word_t    xfer_addr,
	input  arm_mem_pkg::word_t    eff_addr,
	input  arm_mem_pkg::word_t    rd_data,
	output logic                  writeback,
	output arm_mem_pkg::reg_idx_t reg_sel,
	output arm_mem_pkg::word_t    reg_data,
	output logic                  res_busy
);

	import arm_mem_pkg::*;

	res_state_t  state;
	logic [63:0] rot_dbl;
	word_t       load_val;
	reg_idx_t    base_sel;
	word_t       base_addr;
	logic        take;

	// Unaligned word loads come back rotated by the low address bits.
	assign rot_dbl = {rd_data, rd_data} >> {xfer_addr[1:0], 3'b000};
	assign load_val = is_byte ? {24'h000000, rot_dbl[7:0]} : rot_dbl[31:0];

	assign take = (state == RES_IDLE) && done;
	assign res_busy = (state == RES_BASE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RES_IDLE;
			writeback <= 1'b0;
		end else begin
			writeback <= 1'b0;
			case (state)
				RES_IDLE: begin
					if (done) begin
						writeback <= is_load | wb_base;
						state <= (is_load && wb_base) ? RES_BASE : RES_HOLD;
					end
				end
				RES_BASE: begin
					writeback <= 1'b1; // Second write of a load carries the base.
					state <= RES_IDLE;
				end
				RES_HOLD: begin
					if (!done)
						state <= RES_IDLE;
				end
				default: state <= RES_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (res_busy) begin
			reg_sel <= base_sel;
			reg_data <= base_addr;
		end else if (take) begin
			if (is_load) begin
				reg_sel <= rd;
				reg_data <= load_val;
			end else begin
				reg_sel <= rn; // Only used when the store writes its base back.
				reg_data <= eff_addr;
			end
		end
	end

	// The pipeline may move on before the base is written, so keep a copy.
	always_ff @(posedge clk) begin
		if (take) begin
			base_sel <= rn;
			base_addr <= eff_addr;
		end
	end

endmodule

`default_nettype wire

// File: ldst_execute.sv
`default_nettype none

module ldst_execute (
	input  logic                     clk,
	input  logic                     rst_n,
	input  arm_mem_pkg::ldst_class_t cls,
	input  logic                     is_load,
	input  logic                     is_byte,
	input  logic                     pre_index,
	input  logic                     up,
	input  arm_mem_pkg::word_t       op0,
	input  arm_mem_pkg::word_t       op1,
	input  arm_mem_pkg::reg_idx_t    rd,
	input  arm_mem_pkg::word_t       st_data,
	input  logic                     rw_wait,
	input  logic                     res_busy,
	output arm_mem_pkg::word_t       bus_addr,
	output logic                     rd_req,
	output logic                     wr_req,
	output arm_mem_pkg::word_t       wr_data,
	output arm_mem_pkg::reg_idx_t    st_sel,
	output arm_mem_pkg::word_t       eff_addr,
	output arm_mem_pkg::word_t       xfer_addr,
	output logic                     done,
	output logic                     stall
);

	import arm_mem_pkg::*;

	logic single;
	logic issue;
	logic acc_q; // Set for the cycle right after an access completes.

	assign single = (cls == LDST_SINGLE);

	assign eff_addr = up ? op0 + op1 : op0 - op1;
	assign xfer_addr = pre_index ? eff_addr : op0; // Post-indexing uses the old base.
	assign bus_addr = {xfer_addr[31:2], 2'b00};

	// No access while the sequencer writes the base, and none directly after
	// a completion. That idle bus cycle also lets the register file take the
	// loaded value before a following store reads it.
	assign issue = single && !res_busy && !acc_q;
	assign rd_req = issue & is_load;
	assign wr_req = issue & ~is_load;

	assign st_sel = rd;
	assign wr_data = is_byte ? {4{st_data[7:0]}} : st_data;

	assign done = (rd_req | wr_req) & ~rw_wait;

	// A transfer held back by acc_q must keep the pipeline inputs in place.
	assign stall = ((rd_req | wr_req) & rw_wait) | res_busy | (acc_q & single);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_q <= 1'b0;
		end else begin
			acc_q <= done;
		end
	end

endmodule

`default_nettype wire

// File: ldst_decode.sv
`default_nettype none

module ldst_decode (
	input  arm_mem_pkg::insn_t       insn,
	output arm_mem_pkg::ldst_class_t cls,
	output logic                     is_load,
	output logic                     is_byte,
	output logic                     pre_index,
	output logic                     up,
	output logic                     wb_base,
	output arm_mem_pkg::reg_idx_t    rn,
	output arm_mem_pkg::reg_idx_t    rd
);

	import arm_mem_pkg::*;

	logic [3:0] cls_bits;
	logic       single;

	assign cls_bits = {insn[CLS_MSB:CLS_LSB], insn[BIT_SHREG]};

	always_comb begin
		casez (cls_bits)
			4'b0111: cls = LDST_UNDEF; // Register offset with bit 4 set is not a transfer.
			4'b01??: cls = LDST_SINGLE;
			default: cls = LDST_NONE;
		endcase
	end

	assign single = (cls == LDST_SINGLE);

	// Flags only mean something for a real transfer.
	always_comb begin
		if (single) begin
			is_load = insn[BIT_LOAD];
			is_byte = insn[BIT_BYTE];
			pre_index = insn[BIT_PRE];
			up = insn[BIT_UP];
			wb_base = insn[BIT_WB];
		end else begin
			is_load = 1'b0;
			is_byte = 1'b0;
			pre_index = 1'b0;
			up = 1'b0;
			wb_base = 1'b0;
		end
	end

	assign rn = insn[RN_MSB:RN_LSB];
	assign rd = insn[RD_MSB:RD_LSB];

endmodule

`default_nettype wire

// File: arm_mem_pkg.sv
`default_nettype none

package arm_mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [31:0] insn_t;

	// Instruction classes seen by the memory stage.
	typedef enum logic [1:0] {
		LDST_NONE,
		LDST_UNDEF,
		LDST_SINGLE
	} ldst_class_t;

	// States of the register writeback sequencer.
	typedef enum logic [1:0] {
		RES_IDLE,
		RES_BASE,
		RES_HOLD
	} res_state_t;

	// Load/store control bits.
	localparam int BIT_PRE = 24;
	localparam int BIT_UP = 23;
	localparam int BIT_BYTE = 22;
	localparam int BIT_WB = 21;
	localparam int BIT_LOAD = 20;

	// Register fields.
	localparam int RN_MSB = 19;
	localparam int RN_LSB = 16;
	localparam int RD_MSB = 15;
	localparam int RD_LSB = 12;

	// Class field and the register-shift bit that marks the undefined encoding.
	localparam int CLS_MSB = 27;
	localparam int CLS_LSB = 25;
	localparam int BIT_SHREG = 4;

endpackage

`default_nettype wire
